//--- tests/bank_arb_golden.txt
// One cycle per line, hex. Inputs: rd_vld, rd_ram[0..4], rd_idx[0..4],
// wr_vld, wr_ram[0..4], wr_idx[0..4]. Expected: rd_rdy, wr_rdy, rd_cmd_vld, wr_cmd_vld.
1f 0 1 2 3 4 010 011 012 013 014 00 0 0 0 0 0 000 000 000 000 000 03 00 3 0
1c 0 0 2 3 4 000 000 012 013 014 16 0 2 5 0 6 000 101 102 000 104 0c 02 3 1
10 0 0 0 0 4 000 000 000 000 014 15 4 0 5 0 6 100 000 102 000 104 10 04 1 1
00 0 0 0 0 0 000 000 000 000 000 11 4 0 0 0 6 100 000 000 000 104 00 01 0 1
03 0 3 0 0 0 020 021 000 000 000 10 0 0 0 0 6 000 000 000 000 104 02 10 1 1
01 0 0 0 0 0 020 000 000 000 000 00 0 0 0 0 0 000 000 000 000 000 00 00 0 0
09 0 0 0 1 0 020 000 000 023 000 00 0 0 0 0 0 000 000 000 000 000 01 00 1 0
08 0 0 0 1 0 000 000 000 023 000 00 0 0 0 0 0 000 000 000 000 000 08 00 1 0
06 0 7 4 0 0 000 031 032 000 000 00 0 0 0 0 0 000 000 000 000 000 02 00 1 0
15 2 0 4 0 5 040 000 032 000 044 02 0 3 0 0 0 000 111 000 000 000 04 02 1 1
11 2 0 0 0 5 040 000 000 000 044 00 0 0 0 0 0 000 000 000 000 000 10 00 1 0
03 2 6 0 0 0 040 041 000 000 000 00 0 0 0 0 0 000 000 000 000 000 01 00 1 0
0a 0 6 0 1 0 000 041 000 043 000 00 0 0 0 0 0 000 000 000 000 000 02 00 1 0
08 0 0 0 1 0 000 000 000 043 000 1f 0 1 2 4 7 120 121 122 123 124 08 01 1 1
14 0 0 6 0 3 000 000 052 000 054 1e 0 1 2 4 7 000 121 122 123 124 14 02 3 1
01 2 0 0 0 0 060 000 000 000 000 1c 0 0 2 4 7 000 000 122 123 124 00 04 0 1
01 2 0 0 0 0 060 000 000 000 000 18 0 0 0 4 7 000 000 000 123 124 01 08 1 1
06 0 1 0 0 0 000 071 072 000 000 10 0 0 0 0 7 000 000 000 000 124 04 10 1 1
02 0 1 0 0 0 000 071 000 000 000 18 0 0 0 7 5 000 000 000 133 134 02 10 1 1
10 0 0 0 0 4 000 000 000 000 094 08 0 0 0 7 0 000 000 000 133 000 00 00 0 0
10 0 0 0 0 4 000 000 000 000 094 08 0 0 0 7 0 000 000 000 133 000 10 08 1 1
00 0 0 0 0 0 000 000 000 000 000 00 0 0 0 0 0 000 000 000 000 000 00 00 0 0
00 0 0 0 0 0 000 000 000 000 000 00 0 0 0 0 0 000 000 000 000 000 00 00 0 0
00 0 0 0 0 0 000 000 000 000 000 00 0 0 0 0 0 000 000 000 000 000 00 00 0 0

//--- files.f
+incdir+include
verilog/bank_arb_pkg.sv
verilog/occupancy_if.sv
verilog/channel_timer.sv
verilog/ram_timer.sv
verilog/grant_arbiter.sv
verilog/bank_arb_top.sv
tests/tb_bank_arb.sv

//--- Makefile
# Verilator build and run for the bank arbiter testbench.
TOP := tb_bank_arb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- include/tb_occupancy_model.svh
`ifndef TB_OCCUPANCY_MODEL_SVH
`define TB_OCCUPANCY_MODEL_SVH

// Model timers, kept apart from the DUT under the same shift rule.
bank_arb_pkg::timer_t    m_chan [bank_arb_pkg::NUM_CHAN];
bank_arb_pkg::timer_t    m_ram  [bank_arb_pkg::NUM_RAM];

// Predicted outputs for the current cycle.
logic [bank_arb_pkg::NUM_SRC-1:0] m_rd_rdy;
logic [bank_arb_pkg::NUM_SRC-1:0] m_wr_rdy;
logic [1:0]                       m_rd_cmd_vld;
logic                             m_wr_cmd_vld;
bank_arb_pkg::ram_id_t            m_rd_cmd_ram [2];
bank_arb_pkg::line_idx_t          m_rd_cmd_idx [2];
bank_arb_pkg::ram_id_t            m_wr_cmd_ram;
bank_arb_pkg::line_idx_t          m_wr_cmd_idx;
int unsigned                      m_wr_src;

task automatic model_reset();
    m_chan = '{default: '0};
    m_ram  = '{default: '0};
endtask

// Predicts the grants from the requests and the model timers.
task automatic model_predict(
    input logic [bank_arb_pkg::NUM_SRC-1:0] rd_v,
    input bank_arb_pkg::ram_id_t            rd_r [bank_arb_pkg::NUM_SRC],
    input bank_arb_pkg::line_idx_t          rd_i [bank_arb_pkg::NUM_SRC],
    input logic [bank_arb_pkg::NUM_SRC-1:0] wr_v,
    input bank_arb_pkg::ram_id_t            wr_r [bank_arb_pkg::NUM_SRC],
    input bank_arb_pkg::line_idx_t          wr_i [bank_arb_pkg::NUM_SRC]
);
    int slot;
    int unsigned rd_off;
    int unsigned wr_off;
    m_rd_rdy = '0;
    m_wr_rdy = '0;
    m_rd_cmd_vld = '0;
    m_wr_cmd_vld = 1'b0;
    m_rd_cmd_ram = '{default: '0};
    m_rd_cmd_idx = '{default: '0};
    m_wr_cmd_ram = '0;
    m_wr_cmd_idx = '0;
    m_wr_src = 0;
    slot = 0;
    for (int i = 0; i < bank_arb_pkg::NUM_SRC; i++) begin
        rd_off = bank_arb_pkg::RD_BLOCK_DELAY[rd_r[i][2:1]];
        if (rd_v[i] && slot < 2 && !m_chan[rd_r[i][0]][0] && !m_ram[rd_r[i]][rd_off]) begin
            m_rd_rdy[i] = 1'b1;
            m_rd_cmd_vld[slot] = 1'b1;
            m_rd_cmd_ram[slot] = rd_r[i];
            m_rd_cmd_idx[slot] = rd_i[i];
            slot++;
        end
        wr_off = bank_arb_pkg::WR_CMD_DELAY[i] + bank_arb_pkg::WR_BLOCK_DELAY[wr_r[i][2:1]];
        if (wr_v[i] && !m_wr_cmd_vld && !m_ram[wr_r[i]][wr_off] &&
            !m_chan[wr_r[i][0]][bank_arb_pkg::WR_CMD_DELAY[i]]) begin
            m_wr_rdy[i] = 1'b1;
            m_wr_cmd_vld = 1'b1;
            m_wr_cmd_ram = wr_r[i];
            m_wr_cmd_idx = wr_i[i];
            m_wr_src = i;
        end
    end
endtask

// Advances the model timers by one clock, marking the predicted write.
task automatic model_advance();
    int unsigned wr_off;
    wr_off = bank_arb_pkg::WR_CMD_DELAY[m_wr_src] +
        bank_arb_pkg::WR_BLOCK_DELAY[m_wr_cmd_ram[2:1]];
    if (m_wr_cmd_vld) begin
        m_chan[m_wr_cmd_ram[0]][bank_arb_pkg::WR_CMD_DELAY[m_wr_src]] = 1'b1;
        m_ram[m_wr_cmd_ram][wr_off] = 1'b1;
    end
    foreach (m_chan[c]) m_chan[c] = m_chan[c] >> 1;
    foreach (m_ram[r]) m_ram[r] = m_ram[r] >> 1;
endtask

`endif

//--- tests/tb_bank_arb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bank_arb;

    localparam int NUM_VEC     = 24;  // Vector lines in the golden file.
    localparam int VEC_WORDS   = 26;
    localparam int RAND_CYCLES = 400;

    logic                             clk;
    logic                             rst;
    logic [bank_arb_pkg::NUM_SRC-1:0] rd_vld;
    bank_arb_pkg::ram_id_t            rd_ram [bank_arb_pkg::NUM_SRC];
    bank_arb_pkg::line_idx_t          rd_idx [bank_arb_pkg::NUM_SRC];
    logic [bank_arb_pkg::NUM_SRC-1:0] wr_vld;
    bank_arb_pkg::ram_id_t            wr_ram [bank_arb_pkg::NUM_SRC];
    bank_arb_pkg::line_idx_t          wr_idx [bank_arb_pkg::NUM_SRC];
    logic [bank_arb_pkg::NUM_SRC-1:0] rd_rdy;
    logic [bank_arb_pkg::NUM_SRC-1:0] wr_rdy;
    logic [1:0]                       rd_cmd_vld;
    bank_arb_pkg::ram_id_t            rd_cmd_ram [2];
    bank_arb_pkg::line_idx_t          rd_cmd_idx [2];
    logic                             wr_cmd_vld;
    bank_arb_pkg::ram_id_t            wr_cmd_ram;
    bank_arb_pkg::line_idx_t          wr_cmd_idx;

    logic [15:0] golden [NUM_VEC*VEC_WORDS];
    integer      seed;
    int          errors;
    int          checks;

    `include "tb_occupancy_model.svh"

    bank_arb_top u_bank_arb_top (
        .clk        (clk),
        .rst        (rst),
        .rd_vld     (rd_vld),
        .rd_ram     (rd_ram),
        .rd_idx     (rd_idx),
        .wr_vld     (wr_vld),
        .wr_ram     (wr_ram),
        .wr_idx     (wr_idx),
        .rd_rdy     (rd_rdy),
        .wr_rdy     (wr_rdy),
        .rd_cmd_vld (rd_cmd_vld),
        .rd_cmd_ram (rd_cmd_ram),
        .rd_cmd_idx (rd_cmd_idx),
        .wr_cmd_vld (wr_cmd_vld),
        .wr_cmd_ram (wr_cmd_ram),
        .wr_cmd_idx (wr_cmd_idx)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic check_against_model();
        check_value("rd_rdy", rd_rdy, m_rd_rdy);
        check_value("wr_rdy", wr_rdy, m_wr_rdy);
        check_value("rd_cmd_vld", rd_cmd_vld, m_rd_cmd_vld);
        check_value("wr_cmd_vld", wr_cmd_vld, m_wr_cmd_vld);
        check_value("wr_cmd_ram", wr_cmd_ram, m_wr_cmd_ram);
        check_value("wr_cmd_idx", wr_cmd_idx, m_wr_cmd_idx);
        for (int s = 0; s < 2; s++) begin
            check_value($sformatf("rd_cmd_ram[%0d]", s), rd_cmd_ram[s], m_rd_cmd_ram[s]);
            check_value($sformatf("rd_cmd_idx[%0d]", s), rd_cmd_idx[s], m_rd_cmd_idx[s]);
        end
    endtask

    // Granted reads fill the slots in source order.
    task automatic check_slots(input logic [bank_arb_pkg::NUM_SRC-1:0] exp_rdy);
        int slot;
        slot = 0;
        for (int i = 0; i < bank_arb_pkg::NUM_SRC; i++) begin
            if (exp_rdy[i] && slot < 2) begin
                check_value($sformatf("rd_cmd_ram[%0d]", slot), rd_cmd_ram[slot], rd_ram[i]);
                check_value($sformatf("rd_cmd_idx[%0d]", slot), rd_cmd_idx[slot], rd_idx[i]);
                slot++;
            end
        end
    endtask

    task automatic apply_vector(input int base);
        rd_vld = golden[base][bank_arb_pkg::NUM_SRC-1:0];
        wr_vld = golden[base+11][bank_arb_pkg::NUM_SRC-1:0];
        for (int i = 0; i < bank_arb_pkg::NUM_SRC; i++) begin
            rd_ram[i] = bank_arb_pkg::ram_id_t'(golden[base+1+i]);
            rd_idx[i] = bank_arb_pkg::line_idx_t'(golden[base+6+i]);
            wr_ram[i] = bank_arb_pkg::ram_id_t'(golden[base+12+i]);
            wr_idx[i] = bank_arb_pkg::line_idx_t'(golden[base+17+i]);
        end
    endtask

    task automatic make_requests();
        rd_vld = rd_vld & ~m_rd_rdy;  // A granted source drops its request.
        wr_vld = wr_vld & ~m_wr_rdy;
        for (int i = 0; i < bank_arb_pkg::NUM_SRC; i++) begin
            if (!rd_vld[i] && ($random(seed) & 1)) begin
                rd_vld[i] = 1'b1;
                rd_ram[i] = bank_arb_pkg::ram_id_t'($random(seed));
                rd_idx[i] = bank_arb_pkg::line_idx_t'($random(seed));
            end
            if (!wr_vld[i] && (($random(seed) & 3) == 0)) begin
                wr_vld[i] = 1'b1;
                wr_ram[i] = bank_arb_pkg::ram_id_t'($random(seed));
                wr_idx[i] = bank_arb_pkg::line_idx_t'($random(seed));
            end
        end
    endtask

    // **************************************************
    // Main sequence
    // **************************************************
    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        rd_vld = '0;
        wr_vld = '0;
        rd_ram = '{default: '0};
        rd_idx = '{default: '0};
        wr_ram = '{default: '0};
        wr_idx = '{default: '0};
        seed   = 99164;
        errors = 0;
        checks = 0;
        $readmemh("tests/bank_arb_golden.txt", golden);
        model_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < NUM_VEC; n++) begin
            @(negedge clk);
            apply_vector(n * VEC_WORDS);
            model_predict(rd_vld, rd_ram, rd_idx, wr_vld, wr_ram, wr_idx);
            #2;
            check_value("rd_rdy", rd_rdy, golden[n*VEC_WORDS+22]);
            check_value("wr_rdy", wr_rdy, golden[n*VEC_WORDS+23]);
            check_value("rd_cmd_vld", rd_cmd_vld, golden[n*VEC_WORDS+24]);
            check_value("wr_cmd_vld", wr_cmd_vld, golden[n*VEC_WORDS+25]);
            check_slots(golden[n*VEC_WORDS+22][bank_arb_pkg::NUM_SRC-1:0]);
            check_against_model();
            @(posedge clk);
            model_advance();
        end

        for (int n = 0; n < RAND_CYCLES; n++) begin
            @(negedge clk);
            make_requests();
            model_predict(rd_vld, rd_ram, rd_idx, wr_vld, wr_ram, wr_idx);
            #2;
            check_against_model();
            @(posedge clk);
            model_advance();
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // **************************************************
    // Watchdog
    // **************************************************
    initial begin
        #((NUM_VEC + RAND_CYCLES + 20) * 8);
        $display("timeout: the run did not end within %0d cycles",
                 NUM_VEC + RAND_CYCLES + 20);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bank_arb_top.sv
`timescale 1ns/1ps
`default_nettype none

module bank_arb_top (
    input  wire                                   clk,
    input  wire                                   rst,

    // Read requests, index 0 is evict.
    input  wire logic [bank_arb_pkg::NUM_SRC-1:0] rd_vld,
    input  wire bank_arb_pkg::ram_id_t            rd_ram     [bank_arb_pkg::NUM_SRC],
    input  wire bank_arb_pkg::line_idx_t          rd_idx     [bank_arb_pkg::NUM_SRC],

    // Write requests, index 0 is linefill.
    input  wire logic [bank_arb_pkg::NUM_SRC-1:0] wr_vld,
    input  wire bank_arb_pkg::ram_id_t            wr_ram     [bank_arb_pkg::NUM_SRC],
    input  wire bank_arb_pkg::line_idx_t          wr_idx     [bank_arb_pkg::NUM_SRC],

    output logic [bank_arb_pkg::NUM_SRC-1:0]      rd_rdy,
    output logic [bank_arb_pkg::NUM_SRC-1:0]      wr_rdy,

    output logic [1:0]                            rd_cmd_vld,
    output bank_arb_pkg::ram_id_t                 rd_cmd_ram [2],
    output bank_arb_pkg::line_idx_t               rd_cmd_idx [2],

    output logic                                  wr_cmd_vld,
    output bank_arb_pkg::ram_id_t                 wr_cmd_ram,
    output bank_arb_pkg::line_idx_t               wr_cmd_idx
);

    occupancy_if occ ();

    // **************************************************
    // Occupancy timers
    // **************************************************
    channel_timer u_channel_timer (
        .clk (clk),
        .rst (rst),
        .occ (occ.chan)
    );

    ram_timer u_ram_timer (
        .clk (clk),
        .rst (rst),
        .occ (occ.ram)
    );

    // **************************************************
    // Grant logic
    // **************************************************
    grant_arbiter u_grant_arbiter (
        .rd_vld     (rd_vld),
        .rd_ram     (rd_ram),
        .rd_idx     (rd_idx),
        .wr_vld     (wr_vld),
        .wr_ram     (wr_ram),
        .wr_idx     (wr_idx),
        .occ        (occ.arb),
        .rd_rdy     (rd_rdy),
        .wr_rdy     (wr_rdy),
        .rd_cmd_vld (rd_cmd_vld),
        .rd_cmd_ram (rd_cmd_ram),
        .rd_cmd_idx (rd_cmd_idx),
        .wr_cmd_vld (wr_cmd_vld),
        .wr_cmd_ram (wr_cmd_ram),
        .wr_cmd_idx (wr_cmd_idx)
    );

endmodule

`default_nettype wire

//--- verilog/grant_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module grant_arbiter (
    input  wire logic [bank_arb_pkg::NUM_SRC-1:0] rd_vld,
    input  wire bank_arb_pkg::ram_id_t            rd_ram     [bank_arb_pkg::NUM_SRC],
    input  wire bank_arb_pkg::line_idx_t          rd_idx     [bank_arb_pkg::NUM_SRC],
    input  wire logic [bank_arb_pkg::NUM_SRC-1:0] wr_vld,
    input  wire bank_arb_pkg::ram_id_t            wr_ram     [bank_arb_pkg::NUM_SRC],
    input  wire bank_arb_pkg::line_idx_t          wr_idx     [bank_arb_pkg::NUM_SRC],
    occupancy_if.arb                              occ,
    output logic [bank_arb_pkg::NUM_SRC-1:0]      rd_rdy,
    output logic [bank_arb_pkg::NUM_SRC-1:0]      wr_rdy,
    output logic [1:0]                            rd_cmd_vld,
    output bank_arb_pkg::ram_id_t                 rd_cmd_ram [2],
    output bank_arb_pkg::line_idx_t               rd_cmd_idx [2],
    output logic                                  wr_cmd_vld,
    output bank_arb_pkg::ram_id_t                 wr_cmd_ram,
    output bank_arb_pkg::line_idx_t               wr_cmd_idx
);

    logic [bank_arb_pkg::NUM_SRC-1:0] rd_allow;
    logic [bank_arb_pkg::NUM_SRC-1:0] wr_allow;
    logic [bank_arb_pkg::NUM_SRC-1:0] rd_req;
    logic [bank_arb_pkg::NUM_SRC-1:0] wr_req;
    bank_arb_pkg::src_t               wr_src_sel;

    // **************************************************
    // Collision masks
    // **************************************************
    // Only registered timer state is looked at, so the grants
    // never feed back into their own masks in the same cycle.
    always_comb begin
        for (int i = 0; i < bank_arb_pkg::NUM_SRC; i++) begin
            // A read uses its channel in the grant cycle and its RAM after the block delay.
            rd_allow[i] = !occ.chan_timer[rd_ram[i][0]][0] &&
                !occ.ram_timer[rd_ram[i]][bank_arb_pkg::RD_BLOCK_DELAY[rd_ram[i][2:1]]];

            wr_allow[i] = !occ.chan_timer[wr_ram[i][0]][bank_arb_pkg::WR_CMD_DELAY[i]] &&
                !occ.ram_timer[wr_ram[i]][
                    bank_arb_pkg::wr_ram_offset(bank_arb_pkg::src_t'(i), wr_ram[i])];
        end
    end

    assign rd_req = rd_vld & rd_allow;
    assign wr_req = wr_vld & wr_allow;

    // **************************************************
    // Read grant, two slots
    // **************************************************
    always_comb begin
        rd_rdy     = '0;
        rd_cmd_vld = '0;
        rd_cmd_ram = '{default: '0};
        rd_cmd_idx = '{default: '0};
        for (int i = 0; i < bank_arb_pkg::NUM_SRC; i++) begin
            if (rd_req[i]) begin
                if (!rd_cmd_vld[0]) begin
                    rd_rdy[i]     = 1'b1;
                    rd_cmd_vld[0] = 1'b1;
                    rd_cmd_ram[0] = rd_ram[i];
                    rd_cmd_idx[0] = rd_idx[i];
                end else if (!rd_cmd_vld[1]) begin
                    rd_rdy[i]     = 1'b1;
                    rd_cmd_vld[1] = 1'b1;
                    rd_cmd_ram[1] = rd_ram[i];
                    rd_cmd_idx[1] = rd_idx[i];
                end
            end
        end
    end

    // **************************************************
    // Write grant, one per cycle
    // **************************************************
    always_comb begin
        wr_rdy     = '0;
        wr_cmd_vld = 1'b0;
        wr_cmd_ram = '0;
        wr_cmd_idx = '0;
        wr_src_sel = '0;
        for (int i = 0; i < bank_arb_pkg::NUM_SRC; i++) begin
            if (wr_req[i] && !wr_cmd_vld) begin  // Lowest index wins.
                wr_rdy[i]  = 1'b1;
                wr_cmd_vld = 1'b1;
                wr_cmd_ram = wr_ram[i];
                wr_cmd_idx = wr_idx[i];
                wr_src_sel = bank_arb_pkg::src_t'(i);
            end
        end
    end

    // The granted write goes to both timers.
    assign occ.wr_fire = wr_cmd_vld;
    assign occ.wr_src  = wr_src_sel;
    assign occ.wr_ram  = wr_cmd_ram;

    // At most two reads and one write per cycle, and the strobe follows the write grant.
    always_comb begin
        if (!$isunknown({rd_rdy, wr_rdy, occ.wr_fire})) begin
            a_rd_two: assert ($countones(rd_rdy) <= 2);
            a_wr_one: assert ($onehot0(wr_rdy));
            a_wr_fire: assert (occ.wr_fire == (|wr_rdy));
        end
    end

endmodule

`default_nettype wire

//--- verilog/ram_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ram_timer (
    input wire       clk,
    input wire       rst,
    occupancy_if.ram occ
);

    int unsigned          mark_pos;
    bank_arb_pkg::timer_t mark;

    // Command delay of the source plus the block delay of the bank group.
    assign mark_pos = bank_arb_pkg::wr_ram_offset(occ.wr_src, occ.wr_ram);

    always_comb begin
        mark = '0;
        if (occ.wr_fire) begin
            mark[mark_pos] = 1'b1;
        end
    end

    // **************************************************
    // Shift registers, one per RAM
    // **************************************************
    always_ff @(posedge clk) begin
        for (int r = 0; r < bank_arb_pkg::NUM_RAM; r++) begin
            if (rst) begin
                occ.ram_timer[r] <= '0;
            end else if (int'(occ.wr_ram) == r) begin
                occ.ram_timer[r] <= (occ.ram_timer[r] | mark) >> 1;
            end else begin
                occ.ram_timer[r] <= occ.ram_timer[r] >> 1;  // Only the addressed RAM is marked.
            end
        end
    end

    // A second write on the same RAM cycle must have been masked out.
    a_ram_slot_free: assert property (
        @(posedge clk) disable iff (rst)
        occ.wr_fire |-> !occ.ram_timer[occ.wr_ram][mark_pos]
    );

endmodule

`default_nettype wire

//--- verilog/channel_timer.sv
`timescale 1ns/1ps
`default_nettype none

module channel_timer (
    input wire        clk,
    input wire        rst,
    occupancy_if.chan occ
);

    int unsigned          mark_pos;
    bank_arb_pkg::timer_t mark [bank_arb_pkg::NUM_CHAN];

    // A write holds its channel WR_CMD_DELAY cycles after the grant.
    assign mark_pos = bank_arb_pkg::WR_CMD_DELAY[occ.wr_src];

    always_comb begin
        for (int c = 0; c < bank_arb_pkg::NUM_CHAN; c++) begin
            mark[c] = '0;
            if (occ.wr_fire && (int'(occ.wr_ram[0]) == c)) begin
                mark[c][mark_pos] = 1'b1;
            end
        end
    end

    // **************************************************
    // Shift registers
    // **************************************************
    always_ff @(posedge clk) begin
        for (int c = 0; c < bank_arb_pkg::NUM_CHAN; c++) begin
            if (rst) begin
                occ.chan_timer[c] <= '0;
            end else begin
                occ.chan_timer[c] <= (occ.chan_timer[c] | mark[c]) >> 1;
            end
        end
    end

    // The arbiter only grants a write whose channel slot is still free.
    a_chan_slot_free: assert property (
        @(posedge clk) disable iff (rst)
        occ.wr_fire |-> !occ.chan_timer[occ.wr_ram[0]][mark_pos]
    );

endmodule

`default_nettype wire

//--- verilog/occupancy_if.sv
`timescale 1ns/1ps
`default_nettype none

interface occupancy_if;

    // Write granted in this cycle. wr_fire is high for that cycle only.
    logic                 wr_fire;
    bank_arb_pkg::src_t    wr_src;
    bank_arb_pkg::ram_id_t wr_ram;

    // Future occupancy, as registered by the two timers.
    bank_arb_pkg::timer_t chan_timer [bank_arb_pkg::NUM_CHAN];
    bank_arb_pkg::timer_t ram_timer  [bank_arb_pkg::NUM_RAM];

    modport arb (
        output wr_fire, wr_src, wr_ram,
        input  chan_timer, ram_timer
    );

    modport chan (
        input  wr_fire, wr_src, wr_ram,
        output chan_timer
    );

    modport ram (
        input  wr_fire, wr_src, wr_ram,
        output ram_timer
    );

endinterface

`default_nettype wire

//--- verilog/bank_arb_pkg.sv
`default_nettype none

package bank_arb_pkg;

    // **************************************************
    // Sizes
    // **************************************************
    localparam int unsigned NUM_SRC    = 5;  // Index 0 is evict or linefill, then N, S, E, W.
    localparam int unsigned NUM_RAM    = 8;
    localparam int unsigned NUM_CHAN   = 2;
    localparam int unsigned NUM_GRP    = 4;
    localparam int unsigned TIMER_W    = 20;
    localparam int unsigned RAM_ID_W   = 3;
    localparam int unsigned LINE_IDX_W = 9;
    localparam int unsigned SRC_W      = 3;

    // Bit 0 of a RAM id is the channel, bits 2 to 1 the bank group.
    typedef logic [RAM_ID_W-1:0]   ram_id_t;
    typedef logic [LINE_IDX_W-1:0] line_idx_t;
    typedef logic [SRC_W-1:0]      src_t;

    // Bit k set means the resource is busy k cycles from now.
    typedef logic [TIMER_W-1:0]    timer_t;

    // **************************************************
    // Delay tables
    // **************************************************

    // Cycles from a write grant to its use of the channel, per source.
    localparam int unsigned WR_CMD_DELAY [NUM_SRC] = '{2, 3, 4, 5, 6};

    // Cycles from a grant to the RAM access, per bank group.
    localparam int unsigned RD_BLOCK_DELAY [NUM_GRP] = '{1, 2, 3, 4};
    localparam int unsigned WR_BLOCK_DELAY [NUM_GRP] = '{8, 7, 6, 5};

    // Offset in the RAM timer where a write from src to ram lands.
    // The largest value is 6 + 8 = 14.
    function automatic int unsigned wr_ram_offset(input src_t src, input ram_id_t ram);
        return WR_CMD_DELAY[src] + WR_BLOCK_DELAY[ram[2:1]];
    endfunction

endpackage

`default_nettype wire
